// File: eeprom_ctrl.f
+incdir+include
logic/eeprom_pkg.sv
logic/eeprom_axil_regs.sv
logic/eeprom_serial_master.sv
logic/eeprom_ctrl_top.sv
bench/eeprom_model.sv
bench/tb_eeprom_ctrl.sv

// File: Bender.yml
package:
  name: eeprom_ctrl

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/eeprom_pkg.sv
      - logic/eeprom_axil_regs.sv
      - logic/eeprom_serial_master.sv
      - logic/eeprom_ctrl_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/eeprom_model.sv
      - bench/tb_eeprom_ctrl.sv

// File: bench/tb_eeprom_ctrl.sv
`timescale 1ns/100ps
`include "eeprom_ctrl_macros.svh"

module tb_eeprom_ctrl
    import eeprom_pkg::*;
();

    localparam int          TIMEOUT_CYCLES = 60 * 2000;
    localparam logic [31:0] FULL_MASK      = 32'hFFFF_FFFF;

    logic        CLK;
    logic        RESET;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata_axi;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata_axi;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        scl;
    logic        sda_oe;
    logic        sda_i;
    logic        sda_pull;
    logic        eeprom_silent;

    logic [31:0]           lfsr_q;
    int                    cycles;
    logic [7:0]            shadow [int];
    logic [`EE_ADDR_W-1:0] written_q [$];
    logic [1:0]            exp_bresp_q [$];
    logic [1:0]            exp_rresp_q [$];
    logic [31:0]           exp_rdata_q [$];
    logic [31:0]           exp_rmask_q [$];
    string                 exp_rname_q [$];

    eeprom_ctrl_top i_dut (.*);

    eeprom_model i_eeprom (
        .scl      (scl),
        .sda      (sda_i),
        .silent   (eeprom_silent),
        .sda_pull (sda_pull)
    );

    assign sda_i = !(sda_oe || sda_pull);   // pull-up on the line

    initial
        CLK = 1'b0;
    always #4 CLK = ~CLK;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // erased bytes read back as ff
    function automatic logic [7:0] ee_expected(input int a);
        if (shadow.exists(a))
            return shadow[a];
        return 8'hFF;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0t: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic report_unexpected(input string channel);
        $display("a %s response arrived that the bench never asked for", channel);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    always @(posedge CLK)
    begin
        if (!RESET)
            check_value(wready, awready, "wready beside awready");   // rise together
        if (!RESET && bvalid && bready)
        begin
            if (exp_bresp_q.size() == 0)
                report_unexpected("write");
            else
                check_value(bresp, exp_bresp_q.pop_front(), "write response");
        end
        if (!RESET && rvalid && rready)
        begin
            if (exp_rresp_q.size() == 0)
                report_unexpected("read");
            else
            begin
                check_value(rresp, exp_rresp_q.pop_front(), "read response");
                check_value(rdata_axi & exp_rmask_q[0], exp_rdata_q.pop_front() & exp_rmask_q[0],
                            exp_rname_q.pop_front());
                void'(exp_rmask_q.pop_front());
            end
        end
    end

    always @(posedge CLK)
    begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    end

    task automatic axi_write(input logic [3:0] a, input logic [31:0] d,
                             input axi_resp_t exp_resp);
        exp_bresp_q.push_back(exp_resp);
        @(posedge CLK);
        awaddr    <= a;
        awvalid   <= 1'b1;
        wdata_axi <= d;
        wstrb     <= 4'hF;
        wvalid    <= 1'b1;
        do
            @(posedge CLK);
        while (!awready);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        repeat (rand_bits(2))
            @(posedge CLK);
        bready <= 1'b1;
        do
            @(posedge CLK);
        while (!bvalid);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] a, input logic [31:0] exp_data,
                            input logic [31:0] mask, input axi_resp_t exp_resp,
                            input string what, output logic [31:0] data);
        exp_rresp_q.push_back(exp_resp);
        exp_rdata_q.push_back(exp_data);
        exp_rmask_q.push_back(mask);
        exp_rname_q.push_back(what);
        @(posedge CLK);
        araddr  <= a;
        arvalid <= 1'b1;
        do
            @(posedge CLK);
        while (!arready);
        arvalid <= 1'b0;
        repeat (rand_bits(2))
            @(posedge CLK);
        rready <= 1'b1;
        do
            @(posedge CLK);
        while (!rvalid);
        data = rdata_axi;
        rready <= 1'b0;
    endtask

    task automatic issue_command(input ee_op_t op, input logic [`EE_ADDR_W-1:0] a,
                                 input logic [7:0] d, input axi_resp_t exp_resp);
        axi_write(`EE_REG_CMD, {op, 12'b0, a, d}, exp_resp);
    endtask

    task automatic wait_idle(input logic exp_nack);
        logic [31:0] status;
        status = 32'h1;
        while (status[0])   // upper bits stay zero while polling
            axi_read(`EE_REG_STATUS, 32'h0, 32'hFFFF_FFFC, RESP_OKAY, "status poll", status);
        check_value(status, {30'b0, exp_nack, 1'b0}, "status after transfer");
    endtask

    task automatic write_byte(input logic [`EE_ADDR_W-1:0] a, input logic [7:0] d);
        issue_command(EE_OP_WRITE, a, d, RESP_OKAY);
        shadow[a] = d;
        written_q.push_back(a);
        wait_idle(1'b0);
    endtask

    task automatic read_and_check(input logic [`EE_ADDR_W-1:0] a);
        logic [31:0] data;
        issue_command(EE_OP_READ, a, 8'h00, RESP_OKAY);
        wait_idle(1'b0);
        axi_read(`EE_REG_RDATA, {24'b0, ee_expected(a)}, FULL_MASK, RESP_OKAY,
                 "read data", data);
    endtask

    initial
    begin
        logic [31:0]           data;
        logic [`EE_ADDR_W-1:0] a;
        logic [7:0]            d;
        RESET         = 1'b1;
        awaddr        = '0;
        awvalid       = 1'b0;
        wdata_axi     = '0;
        wstrb         = '0;
        wvalid        = 1'b0;
        bready        = 1'b0;
        araddr        = '0;
        arvalid       = 1'b0;
        rready        = 1'b0;
        eeprom_silent = 1'b0;
        lfsr_q        = 32'h978d_873d;
        cycles        = 0;
        repeat (16)
            @(posedge CLK);
        RESET <= 1'b0;

        check_value(scl, 1'b1, "scl after reset");
        check_value(sda_oe, 1'b0, "sda_oe after reset");
        axi_read(`EE_REG_STATUS, 32'h0, FULL_MASK, RESP_OKAY, "status after reset", data);
        axi_read(`EE_REG_RDATA, 32'h0, FULL_MASK, RESP_OKAY, "rdata after reset", data);

        write_byte(11'h5A3, 8'h3C);
        read_and_check(11'h5A3);
        read_and_check(11'h0F0);   // never written

        for (int i = 0; i < 40; i++)
        begin
            a = `EE_ADDR_W'(rand_bits(`EE_ADDR_W));
            d = 8'(rand_bits(8));
            if (rand_bits(1) == 0)
                write_byte(a, d);
            else
            begin
                if (rand_bits(1) == 1)   // revisit a written byte
                    a = written_q[rand_bits(5) % written_q.size()];
                read_and_check(a);
            end
        end

        // second command refused while the first runs
        a = `EE_ADDR_W'(rand_bits(`EE_ADDR_W));
        d = 8'(rand_bits(8));
        issue_command(EE_OP_WRITE, a, d, RESP_OKAY);
        shadow[a] = d;
        written_q.push_back(a);
        issue_command(EE_OP_WRITE, a, ~d, RESP_SLVERR);
        wait_idle(1'b0);
        read_and_check(a);

        a = written_q[0];
        @(posedge CLK);
        eeprom_silent <= 1'b1;
        issue_command(EE_OP_WRITE, a, ~ee_expected(a), RESP_OKAY);
        wait_idle(1'b1);
        check_value(i_eeprom.mem[a], ee_expected(a), "model memory after nack");
        @(posedge CLK);
        eeprom_silent <= 1'b0;
        read_and_check(a);   // nack cleared by this command

        axi_write(`EE_REG_STATUS, 32'h0, RESP_SLVERR);
        axi_write(`EE_REG_RDATA, 32'h0, RESP_SLVERR);
        axi_write(4'hC, FULL_MASK, RESP_DECERR);
        axi_read(4'hC, 32'h0, FULL_MASK, RESP_DECERR, "unmapped read", data);
        axi_read(`EE_REG_STATUS, 32'h0, FULL_MASK, RESP_OKAY, "final status", data);

        repeat (4)
            @(posedge CLK);
        if (exp_bresp_q.size() != 0 || exp_rresp_q.size() != 0)
        begin
            $display("responses missing, %0d write and %0d read never arrived",
                     exp_bresp_q.size(), exp_rresp_q.size());
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
        else
        begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// File: bench/eeprom_model.sv
`timescale 1ns/100ps

module eeprom_model (
    input  logic scl,
    input  logic sda,
    input  logic silent,
    output logic sda_pull
);

    typedef enum logic [2:0] {M_IDLE, M_RX, M_ACK, M_TX, M_TXACK} model_state_t;

    logic [7:0]   mem [0:2047];
    logic [10:0]  ptr;
    logic [7:0]   shreg;
    logic         rw;
    int           bit_cnt;
    int           byte_idx;
    model_state_t state;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hFF;   // erased part
        ptr      = '0;
        rw       = 1'b0;
        state    = M_IDLE;
        sda_pull = 1'b0;
    end

    // control, address low, write data
    task automatic take_byte();
        if (silent || (byte_idx == 0 && shreg[7:4] != 4'b1010))
            state = M_IDLE;
        else
        begin
            if (byte_idx == 0)
            begin
                rw        = shreg[0];
                ptr[10:8] = shreg[3:1];
            end
            else if (byte_idx == 1)
                ptr[7:0] = shreg;
            else
                mem[ptr] = shreg;
            sda_pull = 1'b1;
            state    = M_ACK;
        end
        byte_idx = byte_idx + 1;
    endtask

    always @(negedge sda)
    begin
        if (scl === 1'b1)   // start or repeated start
        begin
            state    = M_RX;
            bit_cnt  = 0;
            byte_idx = 0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            state    = M_IDLE;
            sda_pull = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (state == M_RX)
        begin
            shreg   = {shreg[6:0], sda};
            bit_cnt = bit_cnt + 1;
        end
    end

    always @(negedge scl)
    begin
        case (state)
            M_RX:
            begin
                if (bit_cnt == 8)
                    take_byte();
            end
            M_ACK:
            begin
                sda_pull = 1'b0;
                bit_cnt  = 0;
                state    = M_RX;
                if (rw)
                begin
                    shreg    = mem[ptr];
                    sda_pull = !shreg[7];
                    bit_cnt  = 1;
                    state    = M_TX;
                end
            end
            M_TX:
            begin
                if (bit_cnt == 8)
                begin
                    sda_pull = 1'b0;   // master answers with nack
                    state    = M_TXACK;
                end
                else
                begin
                    sda_pull = !shreg[7-bit_cnt];
                    bit_cnt  = bit_cnt + 1;
                end
            end
            M_TXACK:
                state = M_IDLE;
            default:
                ;
        endcase
    end

endmodule

// File: logic/eeprom_ctrl_top.sv
`timescale 1ns/100ps
`include "eeprom_ctrl_macros.svh"

module eeprom_ctrl_top
    import eeprom_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata_axi,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata_axi,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    output logic        scl,
    output logic        sda_oe,
    input  logic        sda_i
);

    // command and completion between register block and bus master
    logic                  start;
    ee_op_t                op;
    logic [`EE_ADDR_W-1:0] addr;
    logic [`EE_DATA_W-1:0] wdata;
    logic                  busy;
    logic                  done;
    logic                  nack;
    logic [`EE_DATA_W-1:0] rdata;

    eeprom_axil_regs i_regs (.*);

    eeprom_serial_master i_master (.*);

endmodule

// File: logic/eeprom_serial_master.sv
`timescale 1ns/100ps
`include "eeprom_ctrl_macros.svh"

module eeprom_serial_master
    import eeprom_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  start,
    input  ee_op_t                op,
    input  logic [`EE_ADDR_W-1:0] addr,
    input  logic [`EE_DATA_W-1:0] wdata,
    output logic                  busy,
    output logic                  done,
    output logic                  nack,
    output logic [`EE_DATA_W-1:0] rdata,
    output logic                  scl,
    output logic                  sda_oe,
    input  logic                  sda_i
);

    localparam int DIV_W = $clog2(`EE_SCL_DIV + 1);

    ee_bus_state_t         state;
    logic [DIV_W-1:0]      div_cnt;
    logic [1:0]            quarter;
    logic                  tick;
    logic [`EE_DATA_W-1:0] shreg;
    logic [2:0]            bit_cnt;
    logic [1:0]            byte_idx;   // 0 ctrl, 1 addr low, 2 data or read ctrl
    logic                  ack_n;
    ee_op_t                op_q;
    logic [`EE_ADDR_W-1:0] addr_q;
    logic [`EE_DATA_W-1:0] wdata_q;

    assign tick = (div_cnt == DIV_W'(`EE_SCL_DIV - 1));
    assign busy = (state != IDLE);
    assign done = (state == DONE);

    // quarter 0 low, 1 and 2 high, 3 low
    always_ff @(posedge CLK)
    begin
        if (RESET || state == IDLE)
        begin
            div_cnt <= '0;
            quarter <= 2'd1;   // transfer opens with scl already high
        end
        else if (tick)
        begin
            div_cnt <= '0;
            quarter <= quarter + 2'd1;
        end
        else
            div_cnt <= div_cnt + 1'b1;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= IDLE;
            scl      <= 1'b1;
            sda_oe   <= 1'b0;
            nack     <= 1'b0;
            rdata    <= '0;
            bit_cnt  <= '0;
            byte_idx <= '0;
        end
        else if (state == IDLE)
        begin
            if (start)
            begin
                op_q     <= op;
                addr_q   <= addr;
                wdata_q  <= wdata;
                shreg    <= {`EE_DEV_CODE, addr[`EE_ADDR_W-1:8], 1'b0};
                bit_cnt  <= '0;
                byte_idx <= '0;
                nack     <= 1'b0;
                state    <= START;
            end
        end
        else if (state == DONE)
            state <= IDLE;
        else if (tick)
        begin
            case (quarter)
                2'd3:   // entering quarter 0, data changes
                begin
                    case (state)
                        SEND_BYTE: sda_oe <= ~shreg[`EE_DATA_W-1];
                        STOP:      sda_oe <= 1'b1;
                        default:   sda_oe <= 1'b0;   // ack slots and read bits
                    endcase
                end
                2'd0:
                    scl <= 1'b1;
                2'd1:   // scl high, sample or make start/stop
                begin
                    case (state)
                        START, RESTART: sda_oe <= 1'b1;
                        STOP:           sda_oe <= 1'b0;
                        GET_ACK:        ack_n  <= sda_i;
                        RECV_BYTE:      shreg  <= {shreg[`EE_DATA_W-2:0], sda_i};
                        default:        ;
                    endcase
                end
                default:
                begin
                    if (state != STOP)
                        scl <= 1'b0;   // bus left released after stop
                    case (state)
                        START:
                            state <= SEND_BYTE;
                        SEND_BYTE:
                        begin
                            shreg   <= shreg << 1;
                            bit_cnt <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7)
                                state <= GET_ACK;
                        end
                        GET_ACK:
                        begin
                            if (ack_n)
                            begin
                                nack  <= 1'b1;   // abort
                                state <= STOP;
                            end
                            else if (byte_idx == 2'd0)
                            begin
                                shreg    <= addr_q[7:0];
                                byte_idx <= 2'd1;
                                state    <= SEND_BYTE;
                            end
                            else if (byte_idx == 2'd1 && op_q == EE_OP_READ)
                                state <= RESTART;
                            else if (byte_idx == 2'd1)
                            begin
                                shreg    <= wdata_q;
                                byte_idx <= 2'd2;
                                state    <= SEND_BYTE;
                            end
                            else if (op_q == EE_OP_READ)
                                state <= RECV_BYTE;
                            else
                                state <= STOP;
                        end
                        RESTART:
                        begin
                            shreg    <= {`EE_DEV_CODE, addr_q[`EE_ADDR_W-1:8], 1'b1};
                            byte_idx <= 2'd2;
                            state    <= SEND_BYTE;
                        end
                        RECV_BYTE:
                        begin
                            bit_cnt <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7)
                            begin
                                rdata <= shreg;
                                state <= SEND_NACK;
                            end
                        end
                        SEND_NACK:
                            state <= STOP;
                        STOP:
                            state <= DONE;
                        default:
                            state <= IDLE;
                    endcase
                end
            endcase
        end
    end

    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        scl && !(state inside {START, RESTART, STOP}) |-> $stable(sda_oe));

    a_done_pulse: assert property (@(posedge CLK) disable iff (RESET)
        done |=> !done);

endmodule

// File: logic/eeprom_axil_regs.sv
`timescale 1ns/100ps
`include "eeprom_ctrl_macros.svh"

module eeprom_axil_regs
    import eeprom_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic [3:0]            awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [31:0]           wdata_axi,
    input  logic [3:0]            wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output axi_resp_t             bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  logic [3:0]            araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [31:0]           rdata_axi,
    output axi_resp_t             rresp,
    output logic                  rvalid,
    input  logic                  rready,
    output logic                  start,
    output ee_op_t                op,
    output logic [`EE_ADDR_W-1:0] addr,
    output logic [`EE_DATA_W-1:0] wdata,
    input  logic                  busy,
    input  logic                  done,
    input  logic                  nack,
    input  logic [`EE_DATA_W-1:0] rdata
);

    localparam logic [31:0] CMD_MASK = 32'h8007_FFFF;   // op, addr, data fields

    logic [31:0]           cmd_q;
    logic [31:0]           cmd_merged;
    logic                  nack_q;
    logic [`EE_DATA_W-1:0] rdata_q;
    logic                  wr_fire;
    logic                  rd_fire;
    logic [3:0]            wr_off;
    logic [3:0]            rd_off;
    logic                  cmd_busy;
    logic                  cmd_ok;

    assign wready   = awready;
    assign wr_fire  = awready && awvalid && wvalid;
    assign rd_fire  = arready && arvalid;
    assign wr_off   = {awaddr[3:2], 2'b00};
    assign rd_off   = {araddr[3:2], 2'b00};
    assign cmd_busy = busy || start;   // launch still in flight counts too
    assign cmd_ok   = wr_fire && (wr_off == `EE_REG_CMD) && !cmd_busy;

    assign op    = ee_op_t'(cmd_q[31]);
    assign addr  = cmd_q[8 +: `EE_ADDR_W];
    assign wdata = cmd_q[`EE_DATA_W-1:0];

    always_comb
    begin
        for (int i = 0; i < 4; i++)
            cmd_merged[8*i +: 8] = wstrb[i] ? wdata_axi[8*i +: 8] : cmd_q[8*i +: 8];
    end

    // single-beat handshakes, one outstanding response per channel
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            awready <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end
        else
        begin
            awready <= awvalid && wvalid && !bvalid && !awready;
            if (wr_fire)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
            arready <= arvalid && !rvalid && !arready;
            if (rd_fire)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (wr_fire)
        begin
            case (wr_off)
                `EE_REG_CMD:                   bresp <= cmd_busy ? RESP_SLVERR : RESP_OKAY;
                `EE_REG_STATUS, `EE_REG_RDATA: bresp <= RESP_SLVERR;   // read only
                default:                       bresp <= RESP_DECERR;
            endcase
        end
        if (rd_fire)
        begin
            rresp <= RESP_OKAY;
            case (rd_off)
                `EE_REG_CMD:    rdata_axi <= cmd_q;
                `EE_REG_STATUS: rdata_axi <= {30'b0, nack_q, cmd_busy};
                `EE_REG_RDATA:  rdata_axi <= {{(32-`EE_DATA_W){1'b0}}, rdata_q};
                default:
                begin
                    rdata_axi <= '0;
                    rresp     <= RESP_DECERR;
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            start   <= 1'b0;
            cmd_q   <= '0;
            nack_q  <= 1'b0;
            rdata_q <= '0;
        end
        else
        begin
            start <= cmd_ok;
            if (cmd_ok)
                cmd_q <= cmd_merged & CMD_MASK;
            if (cmd_ok)
                nack_q <= 1'b0;
            else if (done && nack)
                nack_q <= 1'b1;   // sticky until next command
            if (done && op == EE_OP_READ && !nack)
                rdata_q <= rdata;
        end
    end

    a_start_idle: assert property (@(posedge CLK) disable iff (RESET)
        start |-> !busy);

    a_bvalid_hold: assert property (@(posedge CLK) disable iff (RESET)
        bvalid && !bready |=> bvalid);

endmodule

// File: logic/eeprom_pkg.sv
package eeprom_pkg;

    typedef enum logic {
        EE_OP_WRITE = 1'b0,
        EE_OP_READ  = 1'b1
    } ee_op_t;

    typedef enum logic [3:0] {
        IDLE,
        START,
        SEND_BYTE,
        GET_ACK,
        RESTART,
        RECV_BYTE,
        SEND_NACK,
        STOP,
        DONE
    } ee_bus_state_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_t;

endpackage

// File: include/eeprom_ctrl_macros.svh
`ifndef EEPROM_CTRL_MACROS_SVH
`define EEPROM_CTRL_MACROS_SVH

`define EE_ADDR_W       11
`define EE_DATA_W       8
`define EE_DEV_CODE     4'b1010

// clk cycles per scl quarter
`define EE_SCL_DIV      2

`define EE_REG_CMD      4'h0
`define EE_REG_STATUS   4'h4
`define EE_REG_RDATA    4'h8

`endif
